// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_mips_cpu
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
rtl/mips_pkg.sv
rtl/mips_ctrl_if.sv
rtl/mips_decoder.sv
rtl/mips_alu.sv
rtl/mips_regfile.sv
rtl/mips_load_selector.sv
rtl/mips_datapath.sv
rtl/mips_cpu.sv
tb/tb_mips_cpu.sv

// ==== rtl/mips_alu.sv ====
`default_nettype none

module mips_alu (
  input  mips_pkg::word_t     a,
  input  mips_pkg::word_t     b,
  input  mips_pkg::alu_ctrl_t alu_ctrl,
  input  logic [4:0]          shamt,
  output mips_pkg::word_t     y,
  output logic                zero
);
  import mips_pkg::*;

  always_comb begin
    case (alu_ctrl)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_NOR:  y = ~(a | b);
      ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: y = {31'b0, a < b};
      // Shift amounts come from the instruction and act on b, which is rt
      ALU_SLL:  y = b << shamt;
      ALU_SRL:  y = b >> shamt;
      ALU_SRA:  y = word_t'($signed(b) >>> shamt);
      ALU_LUI:  y = {b[15:0], 16'h0000}; // Immediate moves to the upper half
      default:  y = '0;
    endcase
  end

  assign zero = (y == '0); // Drives the branch decision

endmodule

`default_nettype wire

// ==== rtl/mips_cpu.sv ====
`default_nettype none

module mips_cpu #(
  parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            clk_enable,
  // Instruction memory, read combinationally
  output mips_pkg::word_t instr_address,
  input  mips_pkg::word_t instr_readdata,
  // Data memory, written at the rising edge that ends an SW cycle
  output mips_pkg::word_t data_address,
  output mips_pkg::word_t data_writedata,
  output logic            data_write,
  input  mips_pkg::word_t data_readdata,
  // Status
  output logic            active,
  output mips_pkg::word_t register_v0
);

  mips_ctrl_if ctrl_if ();

  // Decoder turns the fetched word into control for this cycle
  mips_decoder decoder_i (
    .ctrl (ctrl_if.decoder)
  );

  mips_datapath #(
    .RESET_VECTOR (RESET_VECTOR)
  ) datapath_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_enable     (clk_enable),
    .ctrl           (ctrl_if.datapath),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_readdata  (data_readdata),
    .active         (active),
    .register_v0    (register_v0)
  );

endmodule

`default_nettype wire

// ==== rtl/mips_ctrl_if.sv ====
`default_nettype none

interface mips_ctrl_if;
  import mips_pkg::*;

  logic       reg_write;  // Write the register file this cycle
  logic       mem_to_reg; // Write data comes from the load selector
  logic       link;       // Write PC+8, to $31 unless reg_dst picks rd
  logic       reg_dst;    // Destination is rd rather than rt
  logic       alu_src;    // ALU operand b is the extended immediate
  logic       zero_ext;   // Immediate is zero extended
  alu_ctrl_t  alu_ctrl;
  load_ctrl_t load_ctrl;
  logic       pc_src;     // Branch taken
  logic       jump;       // Any jump, J, JAL, JR or JALR
  logic       jump_reg;   // Jump target comes from rs
  logic       mem_write;

  // Fed back from the datapath for decoding
  word_t      instr;
  logic       zero;

  modport decoder (
    output reg_write, mem_to_reg, link, reg_dst, alu_src, zero_ext,
    output alu_ctrl, load_ctrl, pc_src, jump, jump_reg, mem_write,
    input  instr, zero
  );

  modport datapath (
    input  reg_write, mem_to_reg, link, reg_dst, alu_src, zero_ext,
    input  alu_ctrl, load_ctrl, pc_src, jump, jump_reg, mem_write,
    output instr, zero
  );

endinterface

`default_nettype wire

// ==== rtl/mips_datapath.sv ====
`default_nettype none

module mips_datapath #(
  parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clk_enable,
  mips_ctrl_if.datapath        ctrl,
  output mips_pkg::word_t      instr_address,
  input  mips_pkg::word_t      instr_readdata,
  output mips_pkg::word_t      data_address,
  output mips_pkg::word_t      data_writedata,
  output logic                 data_write,
  input  mips_pkg::word_t      data_readdata,
  output logic                 active,
  output mips_pkg::word_t      register_v0
);
  import mips_pkg::*;

  logic      run;           // State may advance this cycle
  word_t     next_pc_q;     // Fetch address for the following cycle
  word_t     pc_plus4;
  word_t     pc_plus8;
  word_t     imm_ext;
  word_t     branch_target;
  word_t     jump_target;
  word_t     pc_follow;
  word_t     rs_val;
  word_t     alu_b;
  word_t     alu_y;
  word_t     load_y;
  word_t     write_data;
  reg_addr_t write_reg;

  assign ctrl.instr = instr_readdata; // Decoder sees the fetched word directly
  assign run = clk_enable && active;

  assign pc_plus4 = instr_address + 32'd4;
  assign pc_plus8 = instr_address + 32'd8; // Return address skips the delay slot

  assign imm_ext = ctrl.zero_ext ? {16'h0000, instr_readdata[15:0]}
                                 : {{16{instr_readdata[15]}}, instr_readdata[15:0]};

  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr_readdata[25:0], 2'b00};

  // Address loaded into next_pc_q at the end of this cycle
  always_comb begin
    if (ctrl.jump) begin
      pc_follow = ctrl.jump_reg ? rs_val : jump_target;
    end else if (ctrl.pc_src) begin
      pc_follow = branch_target;
    end else begin
      pc_follow = next_pc_q + 32'd4; // Sequential flow after the slot
    end
  end

  // PC takes the stored next PC, which leaves one delay slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_address <= RESET_VECTOR;
      next_pc_q     <= RESET_VECTOR + 32'd4;
      active        <= 1'b1;
    end else if (run) begin
      instr_address <= next_pc_q;
      next_pc_q     <= pc_follow;
      if (next_pc_q == '0) begin
        active <= 1'b0; // Jumping to address 0 halts the core
      end
    end
  end

  // JALR links to rd, JAL to $31, other writes go to rd or rt
  always_comb begin
    if (ctrl.reg_dst) begin
      write_reg = instr_readdata[15:11];
    end else if (ctrl.link) begin
      write_reg = 5'd31;
    end else begin
      write_reg = instr_readdata[20:16];
    end
  end

  assign write_data = ctrl.link       ? pc_plus8 :
                      ctrl.mem_to_reg ? load_y   : alu_y;

  mips_regfile regfile_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (ctrl.reg_write && run), // Frozen while disabled or halted
    .ra1    (instr_readdata[25:21]),
    .ra2    (instr_readdata[20:16]),
    .wa     (write_reg),
    .wd     (write_data),
    .rd1    (rs_val),
    .rd2    (data_writedata),
    .reg_v0 (register_v0)
  );

  assign alu_b = ctrl.alu_src ? imm_ext : data_writedata;

  mips_alu alu_i (
    .a        (rs_val),
    .b        (alu_b),
    .alu_ctrl (ctrl.alu_ctrl),
    .shamt    (instr_readdata[10:6]),
    .y        (alu_y),
    .zero     (ctrl.zero)
  );

  assign data_address = alu_y;
  assign data_write   = ctrl.mem_write && run; // SW only, and never while frozen

  mips_load_selector load_sel_i (
    .word        (data_readdata),
    .byte_offset (alu_y[1:0]),
    .load_ctrl   (ctrl.load_ctrl),
    .y           (load_y)
  );

endmodule

`default_nettype wire

// ==== rtl/mips_decoder.sv ====
`default_nettype none

module mips_decoder (
  mips_ctrl_if.decoder ctrl
);
  import mips_pkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = ctrl.instr[31:26];
  assign funct  = ctrl.instr[5:0];

  always_comb begin
    // Everything defaults to a no-op so unknown words change nothing
    ctrl.reg_write  = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.link       = 1'b0;
    ctrl.reg_dst    = 1'b0;
    ctrl.alu_src    = 1'b0;
    ctrl.zero_ext   = 1'b0;
    ctrl.alu_ctrl   = ALU_ADD;
    ctrl.load_ctrl  = LOAD_WORD;
    ctrl.pc_src     = 1'b0;
    ctrl.jump       = 1'b0;
    ctrl.jump_reg   = 1'b0;
    ctrl.mem_write  = 1'b0;

    case (opcode)
      OP_RTYPE: begin
        ctrl.reg_write = 1'b1; // Cleared again below for JR and unknown functs
        ctrl.reg_dst   = 1'b1;
        case (funct)
          FN_ADDU: ctrl.alu_ctrl = ALU_ADD;
          FN_SUBU: ctrl.alu_ctrl = ALU_SUB;
          FN_AND:  ctrl.alu_ctrl = ALU_AND;
          FN_OR:   ctrl.alu_ctrl = ALU_OR;
          FN_XOR:  ctrl.alu_ctrl = ALU_XOR;
          FN_SLT:  ctrl.alu_ctrl = ALU_SLT;
          FN_SLTU: ctrl.alu_ctrl = ALU_SLTU;
          FN_SLL:  ctrl.alu_ctrl = ALU_SLL;
          FN_SRL:  ctrl.alu_ctrl = ALU_SRL;
          FN_SRA:  ctrl.alu_ctrl = ALU_SRA;
          FN_JR: begin
            ctrl.reg_write = 1'b0;
            ctrl.jump      = 1'b1;
            ctrl.jump_reg  = 1'b1;
          end
          FN_JALR: begin
            // Link goes to rd because reg_dst stays set
            ctrl.link     = 1'b1;
            ctrl.jump     = 1'b1;
            ctrl.jump_reg = 1'b1;
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_BEQ: begin
        ctrl.alu_ctrl = ALU_SUB; // Equal operands give a zero difference
        ctrl.pc_src   = ctrl.zero;
      end
      OP_BNE: begin
        ctrl.alu_ctrl = ALU_SUB;
        ctrl.pc_src   = ~ctrl.zero;
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        // The logical immediates take a zero-extended operand
        ctrl.zero_ext  = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
        case (opcode)
          OP_SLTI: ctrl.alu_ctrl = ALU_SLT;
          OP_ANDI: ctrl.alu_ctrl = ALU_AND;
          OP_ORI:  ctrl.alu_ctrl = ALU_OR;
          OP_XORI: ctrl.alu_ctrl = ALU_XOR;
          OP_LUI:  ctrl.alu_ctrl = ALU_LUI;
          default: ctrl.alu_ctrl = ALU_ADD;
        endcase
      end
      OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU: begin
        ctrl.reg_write  = 1'b1;
        ctrl.alu_src    = 1'b1; // Address is base plus signed offset
        ctrl.mem_to_reg = 1'b1;
        case (opcode)
          OP_LB:   ctrl.load_ctrl = LOAD_BYTE;
          OP_LBU:  ctrl.load_ctrl = LOAD_BYTE_U;
          OP_LH:   ctrl.load_ctrl = LOAD_HALF;
          OP_LHU:  ctrl.load_ctrl = LOAD_HALF_U;
          default: ctrl.load_ctrl = LOAD_WORD;
        endcase
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      OP_J: ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.link      = 1'b1; // reg_dst low selects $31
        ctrl.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mips_load_selector.sv ====
`default_nettype none

module mips_load_selector (
  input  mips_pkg::word_t      word,
  input  logic [1:0]           byte_offset,
  input  mips_pkg::load_ctrl_t load_ctrl,
  output mips_pkg::word_t      y
);
  import mips_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // Little-endian lanes, so byte 0 sits in bits 7:0
  assign sel_byte = word[{byte_offset, 3'b000} +: 8];
  assign sel_half = byte_offset[1] ? word[31:16] : word[15:0]; // Bit 0 is ignored

  always_comb begin
    case (load_ctrl)
      LOAD_BYTE:   y = {{24{sel_byte[7]}}, sel_byte};
      LOAD_BYTE_U: y = {24'h000000, sel_byte};
      LOAD_HALF:   y = {{16{sel_half[15]}}, sel_half};
      LOAD_HALF_U: y = {16'h0000, sel_half};
      default:     y = word; // LW passes the word through
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;      // Data word or byte address
  typedef logic [4:0]  reg_addr_t;  // Register number $0..$31
  typedef logic [3:0]  alu_ctrl_t;  // ALU operation selector
  typedef logic [2:0]  load_ctrl_t; // Load width and extension selector

  // ALU operations
  localparam alu_ctrl_t ALU_ADD  = 4'd0;
  localparam alu_ctrl_t ALU_SUB  = 4'd1;
  localparam alu_ctrl_t ALU_AND  = 4'd2;
  localparam alu_ctrl_t ALU_OR   = 4'd3;
  localparam alu_ctrl_t ALU_XOR  = 4'd4;
  localparam alu_ctrl_t ALU_NOR  = 4'd5;
  localparam alu_ctrl_t ALU_SLT  = 4'd6;
  localparam alu_ctrl_t ALU_SLTU = 4'd7;
  localparam alu_ctrl_t ALU_SLL  = 4'd8;
  localparam alu_ctrl_t ALU_SRL  = 4'd9;
  localparam alu_ctrl_t ALU_SRA  = 4'd10;
  localparam alu_ctrl_t ALU_LUI  = 4'd11;

  // Load selections
  localparam load_ctrl_t LOAD_WORD   = 3'd0;
  localparam load_ctrl_t LOAD_BYTE   = 3'd1;
  localparam load_ctrl_t LOAD_BYTE_U = 3'd2;
  localparam load_ctrl_t LOAD_HALF   = 3'd3;
  localparam load_ctrl_t LOAD_HALF_U = 3'd4;

  // Primary opcodes in bits 31:26
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI  = 6'h0A;
  localparam logic [5:0] OP_ANDI  = 6'h0C;
  localparam logic [5:0] OP_ORI   = 6'h0D;
  localparam logic [5:0] OP_XORI  = 6'h0E;
  localparam logic [5:0] OP_LUI   = 6'h0F;
  localparam logic [5:0] OP_LB    = 6'h20;
  localparam logic [5:0] OP_LH    = 6'h21;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_LBU   = 6'h24;
  localparam logic [5:0] OP_LHU   = 6'h25;
  localparam logic [5:0] OP_SW    = 6'h2B;

  // Function codes in bits 5:0 of R-type words
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_SRA  = 6'h03;
  localparam logic [5:0] FN_JR   = 6'h08;
  localparam logic [5:0] FN_JALR = 6'h09;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_SLT  = 6'h2A;
  localparam logic [5:0] FN_SLTU = 6'h2B;

endpackage

`default_nettype wire

// ==== rtl/mips_regfile.sv ====
`default_nettype none

module mips_regfile (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 we,
  input  mips_pkg::reg_addr_t  ra1,
  input  mips_pkg::reg_addr_t  ra2,
  input  mips_pkg::reg_addr_t  wa,
  input  mips_pkg::word_t      wd,
  output mips_pkg::word_t      rd1,
  output mips_pkg::word_t      rd2,
  output mips_pkg::word_t      reg_v0
);
  import mips_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin // $0 is never written
      regs[wa] <= wd;
    end
  end

  // Reads see the old value during a write cycle
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

  assign reg_v0 = regs[2]; // v0 is the result register

endmodule

`default_nettype wire

// ==== tb/tb_mips_cpu.sv ====
`default_nettype none

module tb_mips_cpu;
  timeunit 1ns;
  timeprecision 100ps;
  import mips_pkg::*;

  localparam word_t     RV         = 32'hBFC0_0000; // Reset vector handed to the DUT
  localparam int        HALF       = 20;            // 40 ns clock
  localparam int        MAX_CYCLES = 200;
  localparam word_t     SEED       = 32'h145b1d6f;
  localparam word_t     LFSR_TAPS  = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
  localparam word_t     SIGN       = 32'h8000_0000;
  localparam reg_addr_t R0 = 5'd0;
  localparam reg_addr_t V0 = 5'd2;
  localparam reg_addr_t T0 = 5'd8;
  localparam reg_addr_t T1 = 5'd9;
  localparam reg_addr_t T2 = 5'd10;
  localparam reg_addr_t T3 = 5'd11;
  localparam reg_addr_t RA = 5'd31;

  logic  clk;
  logic  rst_n;
  logic  clk_enable;
  word_t instr_address;
  word_t instr_readdata;
  word_t data_address;
  word_t data_writedata;
  logic  data_write;
  word_t data_readdata;
  logic  active;
  word_t register_v0;

  word_t      imem [256];  // Word index is address bits 9:2
  word_t      dmem [256];
  logic [7:0] prog_len;    // Next free instruction slot
  logic       dmem_fill;   // Reloads the data memory pattern at the next edge
  word_t      lfsr_state;

  mips_cpu #(
    .RESET_VECTOR (RV)
  ) mips_cpu_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_readdata  (data_readdata),
    .active         (active),
    .register_v0    (register_v0)
  );

  initial begin
    clk = 1'b0;
    forever #(HALF) clk = ~clk;
  end

  // Both memories are read combinationally, like the core expects
  assign instr_readdata = imem[instr_address[9:2]];
  assign data_readdata  = dmem[data_address[9:2]];

  // Every bit of the byte address feeds the multiply
  function automatic word_t fill_word(input logic [7:0] idx);
    return ({22'h0, idx, 2'b00} * 32'h9E37_79B1) ^ 32'h0F1E_2D3C;
  endfunction

  always @(posedge clk) begin
    if (dmem_fill) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i[7:0]] <= fill_word(i[7:0]);
      end
    end else if (data_write) begin
      dmem[data_address[9:2]] <= data_writedata; // Store lands at the closing edge
    end
  end

  function automatic word_t lfsr_next(input word_t s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit, low bit of the state is the output
  function automatic word_t rand_bits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic word_t sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t addr_of(input logic [7:0] idx);
    return RV + {22'h0, idx, 2'b00};
  endfunction

  function automatic word_t r_type(input logic [5:0] funct, input reg_addr_t rs,
                                   input reg_addr_t rt, input reg_addr_t rd,
                                   input logic [4:0] sh);
    return {OP_RTYPE, rs, rt, rd, sh, funct};
  endfunction

  function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                   input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_type(input logic [5:0] op, input word_t target);
    return {op, target[27:2]}; // Upper four bits come from the PC
  endfunction

  task automatic check(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // Clears both memories, nops everywhere in the instruction memory
  task automatic new_program();
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = 32'h0;
    end
    prog_len = 8'd0;
    dmem_fill = 1'b1;
    @(posedge clk);
    #1;
    dmem_fill = 1'b0;
  endtask

  task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len = prog_len + 8'd1;
  endtask

  task automatic load_const(input reg_addr_t rt, input word_t v);
    emit(i_type(OP_LUI, R0, rt, v[31:16]));
    emit(i_type(OP_ORI, rt, rt, v[15:0]));
  endtask

  // JR to address 0 with a nop in its delay slot
  task automatic halt_sequence();
    emit(r_type(FN_JR, R0, R0, R0, 5'd0));
    emit(32'h0);
  endtask

  // Resets the core and runs until it halts, optionally dropping clk_enable for a while
  task automatic run_program(input string name, input int stall_at, input int stall_len);
    int cycles;
    cycles = 0;
    rst_n = 1'b0;
    clk_enable = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    while (active !== 1'b0) begin
      if (!clk_enable) begin
        check({name, " data_write while disabled"}, 32'h0, {31'h0, data_write});
      end
      clk_enable = !((cycles >= stall_at) && (cycles < stall_at + stall_len));
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > MAX_CYCLES) begin
        $display("Timeout: %s did not halt within %0d cycles", name, MAX_CYCLES);
        $display("sim failed");
        $fatal(1, "core never halted");
      end
    end
    clk_enable = 1'b1;
  endtask

  // Order is addu subu and or xor slt sltu sll srl sra, then the immediate forms
  function automatic word_t alu_instr(input int op, input logic [15:0] imm,
                                      input logic [4:0] sh);
    case (op)
      0:  return r_type(FN_ADDU, T0, T1, T2, 5'd0);
      1:  return r_type(FN_SUBU, T0, T1, T2, 5'd0);
      2:  return r_type(FN_AND, T0, T1, T2, 5'd0);
      3:  return r_type(FN_OR, T0, T1, T2, 5'd0);
      4:  return r_type(FN_XOR, T0, T1, T2, 5'd0);
      5:  return r_type(FN_SLT, T0, T1, T2, 5'd0);
      6:  return r_type(FN_SLTU, T0, T1, T2, 5'd0);
      7:  return r_type(FN_SLL, R0, T1, T2, sh);
      8:  return r_type(FN_SRL, R0, T1, T2, sh);
      9:  return r_type(FN_SRA, R0, T1, T2, sh);
      10: return i_type(OP_ADDIU, T0, T2, imm);
      11: return i_type(OP_SLTI, T0, T2, imm);
      12: return i_type(OP_ANDI, T0, T2, imm);
      13: return i_type(OP_ORI, T0, T2, imm);
      14: return i_type(OP_XORI, T0, T2, imm);
      default: return i_type(OP_LUI, R0, T2, imm);
    endcase
  endfunction

  function automatic word_t alu_expect(input int op, input word_t a, input word_t b,
                                       input logic [15:0] imm, input logic [4:0] sh);
    case (op)
      0:  return a + b;
      1:  return a - b;
      2:  return a & b;
      3:  return a | b;
      4:  return a ^ b;
      5:  return {31'h0, (a ^ SIGN) < (b ^ SIGN)}; // Flipping the sign bit orders signed values
      6:  return {31'h0, a < b};
      7:  return b << sh;
      8:  return b >> sh;
      9:  return (b >> sh) | (b[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
      10: return a + sext16(imm);
      11: return {31'h0, (a ^ SIGN) < (sext16(imm) ^ SIGN)};
      12: return a & {16'h0, imm};
      13: return a | {16'h0, imm};
      14: return a ^ {16'h0, imm};
      default: return {imm, 16'h0};
    endcase
  endfunction

  task automatic alu_ops();
    word_t       a;
    word_t       b;
    word_t       r;
    word_t       instr;
    logic [15:0] imm;
    logic [4:0]  sh;
    for (int round = 0; round < 3; round++) begin
      if (round == 0) begin
        a = 32'h8000_0001; // Sign corner for the compares
        b = 32'h7FFF_FFF0;
        imm = 16'h8003;
        sh = 5'd31;
      end else begin
        a = rand_bits(32);
        b = rand_bits(32);
        r = rand_bits(16);
        imm = r[15:0];
        r = rand_bits(5);
        sh = r[4:0];
      end
      for (int op = 0; op < 16; op++) begin
        new_program();
        load_const(T0, a);
        load_const(T1, b);
        instr = alu_instr(op, imm, sh);
        emit(instr);
        emit(r_type(FN_OR, T2, R0, V0, 5'd0)); // Move the result into v0
        halt_sequence();
        run_program($sformatf("alu op %0d instr %h", op, instr), -1, 0);
        check($sformatf("alu op %0d instr %h", op, instr),
              alu_expect(op, a, b, imm, sh), register_v0);
      end
    end
  endtask

  // Kinds are lw lb lbu lh lhu
  function automatic logic [5:0] load_op(input int kind);
    case (kind)
      1: return OP_LB;
      2: return OP_LBU;
      3: return OP_LH;
      4: return OP_LHU;
      default: return OP_LW;
    endcase
  endfunction

  function automatic word_t load_expect(input int kind, input word_t v, input logic [1:0] off);
    word_t lane_b;
    word_t lane_h;
    lane_b = v >> {off, 3'b000};   // Byte 0 sits in bits 7:0
    lane_h = v >> {off[1], 4'h0};
    case (kind)
      1: return {{24{lane_b[7]}}, lane_b[7:0]};
      2: return {24'h0, lane_b[7:0]};
      3: return {{16{lane_h[15]}}, lane_h[15:0]};
      4: return {16'h0, lane_h[15:0]};
      default: return v;
    endcase
  endfunction

  task automatic memory_access();
    word_t v;
    string name;
    for (int k = 0; k < 2; k++) begin
      v = (k == 0) ? rand_bits(32) : ~v; // The complement flips every sign bit
      for (int kind = 0; kind < 5; kind++) begin
        for (int off = 0; off < 4; off++) begin
          if ((kind == 0) ? (off == 0) : ((kind < 3) || !off[0])) begin
            name = $sformatf("load kind %0d offset %0d value %h", kind, off, v);
            new_program();
            load_const(T0, v);
            emit(i_type(OP_SW, R0, T0, 16'h0040));
            emit(i_type(load_op(kind), R0, V0, {14'h0010, off[1:0]}));
            halt_sequence();
            run_program(name, -1, 0);
            check(name, load_expect(kind, v, off[1:0]), register_v0);
            check({name, " stored word"}, v, dmem[8'd16]);
            check({name, " neighbour word"}, fill_word(8'd17), dmem[8'd17]);
          end
        end
      end
    end
  endtask

  task automatic branch_delay_slot();
    word_t       r;
    logic [15:0] x;
    logic [15:0] y;
    logic        taken;
    string       name;
    for (int c = 0; c < 4; c++) begin
      r = rand_bits(16);
      x = r[15:0];
      y = c[0] ? x : (x ^ 16'h0100);
      taken = c[1] ? !c[0] : c[0]; // BNE when bit 1 is set
      name = $sformatf("%s %s", c[1] ? "bne" : "beq", c[0] ? "equal" : "differ");
      new_program();
      emit(i_type(OP_ORI, R0, T0, x));
      emit(i_type(OP_ORI, R0, T1, y));
      emit(i_type(c[1] ? OP_BNE : OP_BEQ, T0, T1, 16'd3));
      emit(i_type(OP_ADDIU, V0, V0, 16'd1));   // Delay slot
      emit(i_type(OP_ADDIU, V0, V0, 16'd16));  // Skipped when taken
      emit(i_type(OP_ADDIU, V0, V0, 16'd32));
      emit(i_type(OP_ADDIU, V0, V0, 16'd256)); // Branch target
      halt_sequence();
      run_program(name, -1, 0);
      check(name, taken ? 32'd257 : 32'd305, register_v0);
    end
  endtask

  task automatic jumps_and_links();
    new_program();
    emit(j_type(OP_JAL, addr_of(8'd12)));
    emit(i_type(OP_ADDIU, V0, V0, 16'd1));
    emit(i_type(OP_SW, R0, RA, 16'h0020));        // JAL returns here
    load_const(T2, addr_of(8'd16));
    emit(r_type(FN_JALR, T2, R0, T3, 5'd0));
    emit(i_type(OP_ADDIU, V0, V0, 16'd4));
    emit(i_type(OP_SW, R0, T3, 16'h0024));        // JALR returns here
    emit(j_type(OP_J, addr_of(8'd20)));
    emit(i_type(OP_ADDIU, V0, V0, 16'd64));
    emit(i_type(OP_ADDIU, V0, V0, 16'h0400));
    emit(32'h0);
    emit(i_type(OP_ADDIU, V0, V0, 16'd2));        // Slot 12 is the JAL target
    emit(r_type(FN_JR, RA, R0, R0, 5'd0));
    emit(i_type(OP_ADDIU, V0, V0, 16'd8));
    emit(i_type(OP_ADDIU, V0, V0, 16'h0800));
    emit(i_type(OP_ADDIU, V0, V0, 16'd16));       // Slot 16 is the JALR target
    emit(r_type(FN_JR, T3, R0, R0, 5'd0));
    emit(i_type(OP_ADDIU, V0, V0, 16'd32));
    emit(i_type(OP_ADDIU, V0, V0, 16'h1000));
    halt_sequence();                              // Slot 20 is the J target
    imem[8'd21] = i_type(OP_ADDIU, V0, V0, 16'd128); // Delay slot of the halt jump
    run_program("jumps", -1, 0);
    check("jumps v0", 32'd255, register_v0);
    check("jal link", addr_of(8'd2), dmem[8'd8]);
    check("jalr link", addr_of(8'd7), dmem[8'd9]);
  endtask

  task automatic halt_and_enable();
    word_t held;
    for (int s = 0; s < 3; s++) begin
      new_program();
      emit(i_type(OP_ORI, R0, V0, 16'd5));
      emit(i_type(OP_ORI, R0, R0, 16'h1234));     // Must not stick in $0
      emit(r_type(FN_ADDU, V0, R0, V0, 5'd0));
      emit(i_type(OP_ADDIU, V0, V0, 16'd3));
      emit(i_type(OP_SW, R0, V0, 16'h0030));
      emit(i_type(OP_ADDIU, V0, V0, 16'd7));
      emit(r_type(FN_JR, R0, R0, R0, 5'd0));
      emit(i_type(OP_ADDIU, V0, V0, 16'd9));
      // Later passes freeze the core while the ADDIU of 3 and then the SW is fetched
      run_program(s == 0 ? "halt" : "halt with stall", (s == 0) ? -1 : s + 2, 6);
      check("halt v0", 32'd24, register_v0);
      check("halt stored word", 32'd8, dmem[8'd12]);
      held = register_v0;
      repeat (8) @(posedge clk);
      #1;
      check("v0 after halt", held, register_v0);
      check("active after halt", 32'h0, {31'h0, active});
      check("pc after halt", 32'h0, instr_address);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    clk_enable = 1'b0;
    dmem_fill = 1'b0;
    prog_len = 8'd0;
    lfsr_state = SEED;
    alu_ops();
    memory_access();
    branch_delay_slot();
    jumps_and_links();
    halt_and_enable();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
